// File: tb.f
joy_pkg.sv
board_ctrl_pkg.sv
joy_bus_if.sv
joy_sync_filter.sv
joy_port_map.sv
board_control.sv
arcade_input_top.sv
input_properties.sv
input_checker.sv
tb_arcade_input.sv

// File: Bender.yml
package:
  name: arcade_input

sources:
  - joy_pkg.sv
  - board_ctrl_pkg.sv
  - joy_bus_if.sv
  - joy_sync_filter.sv
  - joy_port_map.sv
  - board_control.sv
  - arcade_input_top.sv
  - target: simulation
    files:
      - input_properties.sv
      - input_checker.sv
      - tb_arcade_input.sv

// File: tb_arcade_input.sv
// testbench top that drives arcade_input_top from a stimulus table, with clock, reset and watchdog
`default_nettype none

module tb_arcade_input import joy_pkg::*, board_ctrl_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int buttons    = 2;
    localparam int active_low = 1;

    // one table row held for the given number of clocks
    typedef struct packed {
        logic [3:0][15:0] board;
        logic [2:0][9:0]  kjoy;
        logic [3:0]       kstart, kcoin, kgfx;
        logic             kpause, kreset, kservice, en4, rot, flp, osd, dl;
        logic [7:0]       cycles;
        logic [2:0]       test;
    } stim_t;

    logic         clk_sys = 1'b0;
    logic         rst;
    raw_joy_t     board_joystick1, board_joystick2, board_joystick3, board_joystick4;
    game_joy_t    key_joy1, key_joy2, key_joy3;
    player_mask_t key_start, key_coin;
    logic         key_pause, key_reset, key_service;
    gfx_mask_t    key_gfx;
    logic         en4way, rot_control, flip, osd_pause, downloading;
    game_joy_t    game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    player_mask_t game_coin, game_start;
    logic         game_service, game_pause, soft_rst;
    gfx_mask_t    gfx_en;

    stim_t       rows [$];
    stim_t       cur;
    logic [2:0]  test_no;
    logic [31:0] rng = 32'hf1281c6a;
    int          limit_cycles = 0;
    string       names [6] = '{"reset values", "random words, rotation", "four-way filter",
                               "coin, start, service", "pause", "soft reset, gfx enables"};

    always #20 clk_sys = ~clk_sys;

    arcade_input_top #(.buttons(buttons), .inputs_active_low(active_low)) dut (.*);
    input_checker #(.buttons(buttons), .inputs_active_low(active_low)) chk (.*);
    bind board_control input_properties props (.*);

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    task automatic add(int n);
        cur.cycles = n;
        cur.test   = test_no;
        rows.push_back(cur);
    endtask

    task automatic apply_row(stim_t r);
        board_joystick1 = r.board[0];
        board_joystick2 = r.board[1];
        board_joystick3 = r.board[2];
        board_joystick4 = r.board[3];
        key_joy1        = r.kjoy[0];
        key_joy2        = r.kjoy[1];
        key_joy3        = r.kjoy[2];
        {key_start, key_coin, key_gfx} = {r.kstart, r.kcoin, r.kgfx};
        {key_pause, key_reset, key_service} = {r.kpause, r.kreset, r.kservice};
        {en4way, rot_control, flip, osd_pause, downloading} = {r.en4, r.rot, r.flp, r.osd, r.dl};
    endtask

    task automatic build_table();
        cur = '0;
        test_no = 0;
        add(4);
        test_no = 1;
        for (int c = 0; c < 4; c++) begin
            cur.rot = c[0];
            cur.flp = c[1];
            for (int k = 0; k < 4; k++) begin
                for (int p = 0; p < 4; p++) begin
                    rng = xorshift32(rng);
                    cur.board[p] = rng[15:0];
                end
                for (int p = 0; p < 3; p++) begin
                    rng = xorshift32(rng);
                    cur.kjoy[p] = rng[9:0];
                end
                add(3);
            end
        end
        // right, up-right, left, down-left, up on every player
        cur = '0;
        test_no = 2;
        cur.en4 = 1'b1;
        cur.board = {4{16'h0001}};
        add(3);
        cur.board = {4{16'h0009}};
        add(3);
        cur.board = {4{16'h0002}};
        add(3);
        cur.board = {4{16'h0006}};
        add(3);
        cur.board = {4{16'h0008}};
        add(3);
        // coin is bit 7 and start bit 6 with two buttons
        cur = '0;
        test_no = 3;
        cur.board[0] = 16'h0080;
        cur.board[2] = 16'h0040;
        add(3);
        {cur.kcoin, cur.kstart} = {4'b0100, 4'b1000};
        add(3);
        cur.kservice = 1'b1;
        add(3);
        cur = '0;
        test_no = 3;
        add(3);
        // pause by held key press, joystick pause bit 8, OSD and download
        test_no = 4;
        cur.kpause = 1'b1;
        add(4);
        cur.kpause = 1'b0;
        add(3);
        cur.board[1] = 16'h0100;
        add(4);
        cur.board[1] = 16'h0000;
        cur.osd = 1'b1;
        add(3);
        cur.kpause = 1'b1;
        add(3);
        {cur.kpause, cur.osd} = 2'b00;
        add(3);
        cur.kpause = 1'b1;
        add(3);
        cur.dl = 1'b1;
        add(3);
        {cur.kpause, cur.dl} = 2'b00;
        add(3);
        test_no = 5;
        cur.kreset = 1'b1;
        add(4);
        cur.kreset = 1'b0;
        add(3);
        cur.kreset = 1'b1;
        add(3);
        cur.kreset = 1'b0;
        cur.kgfx = 4'b0001;
        add(3);
        cur.kgfx = 4'b0000;
        add(3);
        cur.kgfx = 4'b0100;
        add(3);
        cur.kgfx = 4'b0101;
        add(3);
        cur.kgfx = 4'b0000;
        add(3);
    endtask

    // watchdog sized from the table length
    initial begin
        wait (limit_cycles != 0);
        #(limit_cycles * 40);
        $display("timeout: stimulus did not complete within %0d clock cycles", limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int total;
        rst = 1'b1;
        cur = '0;
        apply_row(cur);
        build_table();
        total = 10;
        foreach (rows[i]) total += rows[i].cycles;
        limit_cycles = total + 50;
        repeat (10) @(negedge clk_sys);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            repeat (rows[i].cycles) @(negedge clk_sys);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                chk.report_test(names[rows[i].test]);
            end
        end
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 chk.tests, chk.checks, chk.errors, dut.u_ctrl.props.failures);
        if (chk.errors == 0 && dut.u_ctrl.props.failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: input_checker.sv
// reference model of the input path that compares the DUT outputs every clock and counts errors
`default_nettype none

module input_checker import joy_pkg::*, board_ctrl_pkg::*; #(
    parameter int buttons           = 2,
    parameter int inputs_active_low = 1
) (
    input logic         clk_sys, rst,
    input raw_joy_t     board_joystick1, board_joystick2, board_joystick3, board_joystick4,
    input game_joy_t    key_joy1, key_joy2, key_joy3,
    input player_mask_t key_start, key_coin,
    input logic         key_pause, key_reset, key_service,
    input gfx_mask_t    key_gfx,
    input logic         en4way, rot_control, flip, osd_pause, downloading,
    input game_joy_t    game_joystick1, game_joystick2, game_joystick3, game_joystick4,
    input player_mask_t game_coin, game_start,
    input logic         game_service, game_pause, soft_rst,
    input gfx_mask_t    gfx_en
);

    timeunit 1ns;
    timeprecision 100ps;

    // button bits sit above the directions with start, coin and pause after them
    localparam int   start_pos = 4 + buttons;
    localparam int   coin_pos  = 5 + buttons;
    localparam int   pause_pos = 6 + buttons;
    localparam logic inv       = (inputs_active_low != 0);

    int   errors      = 0;
    int   test_errors = 0;
    int   checks      = 0;
    int   tests       = 0;
    logic armed       = 1'b0;

    raw_joy_t     brd [4];
    game_joy_t    kj [4];
    raw_joy_t     bus_m [4];
    dir_t         held_m [4];
    game_joy_t    exp_joy [4];
    player_mask_t exp_coin, exp_start;
    logic         exp_service, exp_pause, exp_soft;
    gfx_mask_t    exp_gfx, p_gfx;
    logic         p_key, p_jp, p_osd, p_rkey;

    assign brd[0] = board_joystick1;
    assign brd[1] = board_joystick2;
    assign brd[2] = board_joystick3;
    assign brd[3] = board_joystick4;
    assign kj[0]  = key_joy1;
    assign kj[1]  = key_joy2;
    assign kj[2]  = key_joy3;
    assign kj[3]  = '0;

    // bit 3 up, 2 down, 1 left, 0 right
    function automatic dir_t turn(dir_t d, logic rot, logic flp);
        dir_t n;
        n = d;
        if (rot && flp) begin
            n[3] = d[1];
            n[2] = d[0];
            n[1] = d[2];
            n[0] = d[3];
        end else if (rot) begin
            n[3] = d[0];
            n[2] = d[1];
            n[1] = d[3];
            n[0] = d[2];
        end
        return n;
    endfunction

    task automatic compare(string name, logic [15:0] expv, logic [15:0] act);
        checks++;
        if (act !== expv) begin
            errors++;
            test_errors++;
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expv, act);
        end
    endtask

    task automatic report_test(string name);
        tests++;
        $display("test %0d, %s: %s (%0d errors)", tests, name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    always @(posedge clk_sys) begin : model
        dir_t      d;
        game_joy_t m;
        logic      jp;
        // outputs and model both hold last cycle's values here
        if (armed) begin
            compare("game_joystick1", exp_joy[0], game_joystick1);
            compare("game_joystick2", exp_joy[1], game_joystick2);
            compare("game_joystick3", exp_joy[2], game_joystick3);
            compare("game_joystick4", exp_joy[3], game_joystick4);
            compare("game_coin", exp_coin, game_coin);
            compare("game_start", exp_start, game_start);
            compare("game_service", exp_service, game_service);
            compare("game_pause", exp_pause, game_pause);
            compare("soft_rst", exp_soft, soft_rst);
            compare("gfx_en", exp_gfx, gfx_en);
        end
        armed  <= armed | rst;
        jp     = bus_m[0][pause_pos] | bus_m[1][pause_pos];
        p_key  <= key_pause;
        p_jp   <= jp;
        p_osd  <= osd_pause;
        p_rkey <= key_reset;
        p_gfx  <= key_gfx;
        if (rst) begin
            for (int p = 0; p < 4; p++) begin
                bus_m[p]   <= '0;
                held_m[p]  <= '0;
                exp_joy[p] <= {10{inv}};
            end
            exp_coin    <= {4{inv}};
            exp_start   <= {4{inv}};
            exp_service <= inv;
            exp_pause   <= 1'b0;
            exp_soft    <= 1'b0;
            exp_gfx     <= '1;
        end else begin
            for (int p = 0; p < 4; p++) begin
                d = brd[p][3:0];
                if ($countones(d) <= 1) begin
                    held_m[p] <= d;
                end else if (en4way) begin
                    d = held_m[p];
                end
                bus_m[p]     <= {brd[p][15:4], d};
                m            = bus_m[p][9:0] | kj[p];
                exp_joy[p]   <= {m[9:4], turn(m[3:0], rot_control, flip)} ^ {10{inv}};
                exp_coin[p]  <= (bus_m[p][coin_pos] | key_coin[p]) ^ inv;
                exp_start[p] <= (bus_m[p][start_pos] | key_start[p]) ^ inv;
            end
            exp_service <= key_service ^ inv;
            exp_soft    <= key_reset & !p_rkey;
            exp_gfx     <= exp_gfx ^ (key_gfx & ~p_gfx);
            if (downloading) begin
                exp_pause <= 1'b0;
            end else if (osd_pause != p_osd) begin
                exp_pause <= osd_pause;
            end else if ((key_pause && !p_key) || (jp && !p_jp)) begin
                exp_pause <= !exp_pause;
            end
        end
    end

endmodule

`default_nettype wire

// File: input_properties.sv
// concurrent checks on board_control pulses and reset values that the testbench binds into the design
`default_nettype none

module input_properties import board_ctrl_pkg::*; (
    input logic      clk_sys,
    input logic      rst,
    input logic      downloading,
    input logic      game_pause,
    input logic      soft_rst,
    input gfx_mask_t gfx_en
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions
    int failures = 0;

    // soft reset is a single-cycle pulse
    a_soft_rst_pulse : assert property (@(posedge clk_sys) soft_rst |=> !soft_rst)
        else begin
            failures++;
            $error("soft_rst stayed high for two cycles");
        end

    // a running download forces the game out of pause
    a_download_clears_pause : assert property (@(posedge clk_sys) downloading |=> !game_pause)
        else begin
            failures++;
            $error("game_pause set in the cycle after downloading");
        end

    // all layers come back on after reset
    a_gfx_reset : assert property (@(posedge clk_sys) rst |=> (gfx_en == gfx_reset_value))
        else begin
            failures++;
            $error("gfx_en not all ones after rst");
        end

endmodule

`default_nettype wire

// File: arcade_input_top.sv
// top level of the arcade input block, connecting filter, port mapper and board control
`default_nettype none

module arcade_input_top import joy_pkg::*, board_ctrl_pkg::*; #(
    parameter int buttons           = 2,
    parameter int inputs_active_low = 1
) (
    input  logic         clk_sys,
    input  logic         rst,
    // board joysticks
    input  raw_joy_t     board_joystick1,
    input  raw_joy_t     board_joystick2,
    input  raw_joy_t     board_joystick3,
    input  raw_joy_t     board_joystick4,
    // decoded keyboard
    input  game_joy_t    key_joy1,
    input  game_joy_t    key_joy2,
    input  game_joy_t    key_joy3,
    input  player_mask_t key_start,
    input  player_mask_t key_coin,
    input  logic         key_pause,
    input  logic         key_reset,
    input  logic         key_service,
    input  gfx_mask_t    key_gfx,
    // board settings
    input  logic         en4way,
    input  logic         rot_control,
    input  logic         flip,
    input  logic         osd_pause,
    input  logic         downloading,
    // game side
    output game_joy_t    game_joystick1,
    output game_joy_t    game_joystick2,
    output game_joy_t    game_joystick3,
    output game_joy_t    game_joystick4,
    output player_mask_t game_coin,
    output player_mask_t game_start,
    output logic         game_service,
    output logic         game_pause,
    output logic         soft_rst,
    output gfx_mask_t    gfx_en
);

    raw_joy_t board_joy [num_players];

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    joy_bus_if u_bus ();

    joy_sync_filter u_sync (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .en4way    (en4way),
        .board_joy (board_joy),
        .bus       (u_bus.src)
    );

    joy_port_map #(
        .buttons           (buttons),
        .inputs_active_low (inputs_active_low)
    ) u_map (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .bus            (u_bus.sink),
        .key_joy1       (key_joy1),
        .key_joy2       (key_joy2),
        .key_joy3       (key_joy3),
        .key_start      (key_start),
        .key_coin       (key_coin),
        .key_service    (key_service),
        .rot_control    (rot_control),
        .flip           (flip),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_joystick3 (game_joystick3),
        .game_joystick4 (game_joystick4),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service)
    );

    board_control #(
        .buttons           (buttons),
        .inputs_active_low (inputs_active_low)
    ) u_ctrl (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .bus         (u_bus.sink),
        .key_pause   (key_pause),
        .key_reset   (key_reset),
        .key_gfx     (key_gfx),
        .osd_pause   (osd_pause),
        .downloading (downloading),
        .game_pause  (game_pause),
        .soft_rst    (soft_rst),
        .gfx_en      (gfx_en)
    );

endmodule

`default_nettype wire

// File: board_control.sv
// pause toggle, soft reset pulse and graphics layer enables driven by keys and the OSD
`default_nettype none

module board_control import joy_pkg::*, board_ctrl_pkg::*; #(
    parameter int buttons           = 2,
    parameter int inputs_active_low = 1
) (
    input  logic      clk_sys,
    input  logic      rst,
    joy_bus_if.sink   bus,
    input  logic      key_pause,
    input  logic      key_reset,
    input  gfx_mask_t key_gfx,
    input  logic      osd_pause,
    input  logic      downloading,
    output logic      game_pause,
    output logic      soft_rst,
    output gfx_mask_t gfx_en
);

    localparam int pause_bit = pause_bit_of(buttons);

    // the frame supports one to four buttons and a 0/1 polarity setting
    if (buttons < 1 || buttons > 4 ||
        (inputs_active_low != 0 && inputs_active_low != 1)) begin : g_param_check
        $error("board_control: unsupported buttons or inputs_active_low value");
    end

    logic      joy_pause;
    logic      pause_edge;
    logic      last_pause;
    logic      last_joy_pause;
    logic      last_osd_pause;
    logic      last_reset;
    gfx_mask_t last_gfx;

    // pause buttons on players 1 and 2 only
    assign joy_pause  = bus.word[0][pause_bit] | bus.word[1][pause_bit];
    assign pause_edge = (key_pause & ~last_pause) | (joy_pause & ~last_joy_pause);

    // previous levels for edge detection
    always_ff @(posedge clk_sys) begin
        last_pause     <= key_pause;
        last_joy_pause <= joy_pause;
        last_osd_pause <= osd_pause;
        last_reset     <= key_reset;
        last_gfx       <= key_gfx;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause <= 1'b0;
            soft_rst   <= 1'b0;
            gfx_en     <= gfx_reset_value;
        end else begin
            soft_rst <= key_reset & ~last_reset;
            // each layer flips on its own key press
            gfx_en   <= gfx_en ^ (key_gfx & ~last_gfx);
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_pause != last_osd_pause) begin
                // OSD menu wins over the buttons
                game_pause <= osd_pause;
            end else if (pause_edge) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

`default_nettype wire

// File: joy_port_map.sv
// builds the game joystick, coin, start and service inputs with rotation and polarity applied
`default_nettype none

module joy_port_map import joy_pkg::*, board_ctrl_pkg::*; #(
    parameter int buttons           = 2,
    parameter int inputs_active_low = 1
) (
    input  logic         clk_sys,
    input  logic         rst,
    joy_bus_if.sink      bus,
    input  game_joy_t    key_joy1,
    input  game_joy_t    key_joy2,
    input  game_joy_t    key_joy3,
    input  player_mask_t key_start,
    input  player_mask_t key_coin,
    input  logic         key_service,
    input  logic         rot_control,
    input  logic         flip,
    output game_joy_t    game_joystick1,
    output game_joy_t    game_joystick2,
    output game_joy_t    game_joystick3,
    output game_joy_t    game_joystick4,
    output player_mask_t game_coin,
    output player_mask_t game_start,
    output logic         game_service
);

    localparam int start_bit = start_bit_of(buttons);
    localparam int coin_bit  = coin_bit_of(buttons);

    // inversion patterns, also the idle value of each output
    localparam bit           invert   = (inputs_active_low != 0);
    localparam game_joy_t    joy_inv  = {$bits(game_joy_t){invert}};
    localparam player_mask_t mask_inv = player_idle(invert);

    // turn the direction field for rotated screens
    function automatic game_joy_t rotate_dirs(game_joy_t j, logic rot, logic flp);
        dir_t d;
        dir_t r;
        d = j[3:0];
        if (!rot) begin
            r = d;
        end else if (flp) begin
            // up<-left, down<-right, left<-down, right<-up
            r = {d[1], d[0], d[2], d[3]};
        end else begin
            // up<-right, down<-left, left<-up, right<-down
            r = {d[0], d[1], d[3], d[2]};
        end
        return {j[9:4], r};
    endfunction

    game_joy_t    merged [num_players];
    game_joy_t    mapped [num_players];
    player_mask_t joy_coin;
    player_mask_t joy_start;

    always_comb begin
        // keyboard players 1 to 3, player 4 has no key word
        merged[0] = bus.word[0][9:0] | key_joy1;
        merged[1] = bus.word[1][9:0] | key_joy2;
        merged[2] = bus.word[2][9:0] | key_joy3;
        merged[3] = bus.word[3][9:0];
        for (int p = 0; p < num_players; p++) begin
            mapped[p]    = rotate_dirs(merged[p], rot_control, flip) ^ joy_inv;
            joy_coin[p]  = bus.word[p][coin_bit];
            joy_start[p] = bus.word[p][start_bit];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= joy_inv;
            game_joystick2 <= joy_inv;
            game_joystick3 <= joy_inv;
            game_joystick4 <= joy_inv;
            game_coin      <= mask_inv;
            game_start     <= mask_inv;
            game_service   <= invert;
        end else begin
            game_joystick1 <= mapped[0];
            game_joystick2 <= mapped[1];
            game_joystick3 <= mapped[2];
            game_joystick4 <= mapped[3];
            game_coin      <= (joy_coin | key_coin) ^ mask_inv;
            game_start     <= (joy_start | key_start) ^ mask_inv;
            game_service   <= key_service ^ invert;
        end
    end

endmodule

`default_nettype wire

// File: joy_sync_filter.sv
// registers the board joystick words and optionally limits the directions to four-way movement
`default_nettype none

module joy_sync_filter import joy_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst,
    input  logic     en4way,
    input  raw_joy_t board_joy [num_players],
    joy_bus_if.src   bus
);

    // last direction seen with at most one bit pressed
    dir_t held [num_players];
    // direction that goes onto the bus next cycle
    dir_t filt [num_players];
    // at most one direction pressed, per player
    logic [num_players-1:0] single;

    always_comb begin
        for (int p = 0; p < num_players; p++) begin
            single[p] = ($countones(board_joy[p][3:0]) <= 1);
            // diagonals repeat the last clean direction in four-way mode
            if (en4way && !single[p]) begin
                filt[p] = held[p];
            end else begin
                filt[p] = board_joy[p][3:0];
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int p = 0; p < num_players; p++) begin
                bus.word[p] <= '0;
                held[p]     <= '0;
            end
        end else begin
            for (int p = 0; p < num_players; p++) begin
                // buttons, coin, start and pause pass straight through
                bus.word[p] <= {board_joy[p][15:4], filt[p]};
                if (single[p]) begin
                    held[p] <= board_joy[p][3:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: joy_bus_if.sv
// registered joystick words shared by the filter, the port mapper and the board control
`default_nettype none

interface joy_bus_if import joy_pkg::*; ();

    // one word per player, player 1 at index 0
    // levels only, refreshed every clock
    raw_joy_t word [num_players];

    // filter stage drives the words
    modport src (
        output word
    );

    // mapping and control blocks only look
    modport sink (
        input word
    );

endinterface

`default_nettype wire

// File: board_ctrl_pkg.sv
// types and reset values for board control outputs, imported by the mapping and control blocks
`default_nettype none

package board_ctrl_pkg;

    // one bit per player, used for coin and start
    typedef logic [3:0] player_mask_t;

    // one enable per graphics layer
    typedef logic [3:0] gfx_mask_t;

    // all layers visible out of reset
    localparam gfx_mask_t gfx_reset_value = '1;

    // idle coin/start mask for the given input polarity
    function automatic player_mask_t player_idle(bit active_low);
        return {$bits(player_mask_t){active_low}};
    endfunction

endpackage

`default_nettype wire

// File: joy_pkg.sv
// joystick word types and button bit placement, imported by the input path modules
`default_nettype none

package joy_pkg;

    // raw word as delivered by the board, 16 bits per player
    typedef logic [15:0] raw_joy_t;

    // word handed to the game core
    typedef logic [9:0] game_joy_t;

    // direction field: bit 0 right, 1 left, 2 down, 3 up
    typedef logic [3:0] dir_t;

    // number of joystick ports on the board
    localparam int num_players = 4;

    // buttons sit right above the four directions
    // and start, coin and pause follow the last button

    function automatic int start_bit_of(int n_buttons);
        return 4 + n_buttons;
    endfunction

    function automatic int coin_bit_of(int n_buttons);
        return 5 + n_buttons;
    endfunction

    function automatic int pause_bit_of(int n_buttons);
        return 6 + n_buttons;
    endfunction

endpackage

`default_nettype wire
